//--- tomasulo_defines.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// widths, depths and pipeline length
// for the tomasulo issue core
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef TOMASULO_DEFINES_SVH
`define TOMASULO_DEFINES_SVH

// datapath and register file
`define DATA_W        32
`define REG_N         8
`define REG_W         3

// instruction format is op, dest, src_a, src_b
`define OP_W          3
`define INSTR_W       12

// buffering
`define QUEUE_DEPTH   6
`define STATION_DEPTH 6
`define EXEC_STAGES   3

`endif

//--- tomasulo_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared types for the core
// opcodes, instruction word, cdb
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "tomasulo_defines.svh"

package tomasulo_pkg;

  // only ADDF and MULTF reach the station
  // everything else is dropped at issue
  typedef enum logic [`OP_W-1:0] {
    NOP   = 3'd0,
    LD    = 3'd1,
    ST    = 3'd2,
    ADDF  = 3'd3,
    MULTF = 3'd4
  } opcode_t;

  // op sits in the top bits of the 12-bit word
  typedef struct packed {
    opcode_t           op;
    logic [`REG_W-1:0] dest;
    logic [`REG_W-1:0] src_a;
    logic [`REG_W-1:0] src_b;
  } instr_t;

  // result broadcast, register number is the tag
  typedef struct packed {
    logic               valid;
    logic [`REG_W-1:0]  dest;
    logic [`DATA_W-1:0] data;
  } cdb_t;

endpackage

`default_nettype wire

//--- tomasulo_ifs.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// issue_if, issue unit to station
// exec_if, station to exec pipe
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

`include "tomasulo_defines.svh"

interface issue_if import tomasulo_pkg::*; ();
  logic               valid;
  opcode_t            op;
  logic [`REG_W-1:0]  dest;
  // while an operand is not ready its data field
  // carries the source register number instead
  logic [`DATA_W-1:0] a_data;
  logic               a_ready;
  logic [`DATA_W-1:0] b_data;
  logic               b_ready;
  // no free slot in the station
  logic               full;

  modport source (output valid, op, dest, a_data, a_ready, b_data, b_ready,
                  input full);
  modport sink   (input valid, op, dest, a_data, a_ready, b_data, b_ready,
                  output full);
endinterface

interface exec_if import tomasulo_pkg::*; ();
  // at most one dispatch per cycle
  logic               valid;
  opcode_t            op;
  logic [`REG_W-1:0]  dest;
  logic [`DATA_W-1:0] a;
  logic [`DATA_W-1:0] b;

  modport source (output valid, op, dest, a, b);
  modport sink   (input valid, op, dest, a, b);
endinterface

`default_nettype wire

//--- instr_queue.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// instr_queue, six-entry circular
// instruction FIFO with full flag
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

`include "tomasulo_defines.svh"

module instr_queue import tomasulo_pkg::*; (
  input  logic   clk,
  input  logic   rst,
  input  logic   push,
  input  instr_t push_data,
  input  logic   pop,
  output instr_t head,
  output logic   head_valid,
  output logic   full
);

  localparam int PTR_W = $clog2(`QUEUE_DEPTH);
  localparam int CNT_W = $clog2(`QUEUE_DEPTH + 1);

  instr_t             mem [`QUEUE_DEPTH];
  logic [PTR_W-1:0]   wr_ptr;
  logic [PTR_W-1:0]   rd_ptr;
  logic [CNT_W-1:0]   count;
  logic               do_push;
  logic               do_pop;

  // a strobe while full is dropped
  assign do_push    = push && !full;
  assign do_pop     = pop && head_valid;
  assign full       = (count == CNT_W'(`QUEUE_DEPTH));
  assign head_valid = (count != '0);
  assign head       = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // pointers wrap at depth, not at a power of two
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_W'(`QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(`QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // push and pop together leave the count alone
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // storage, written on the strobe edge
  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

endmodule

`default_nettype wire

//--- issue_unit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// issue_unit, head decode, stall
// check, operand read, station write
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

`include "tomasulo_defines.svh"

module issue_unit import tomasulo_pkg::*; (
  input  instr_t             head,
  input  logic               head_valid,
  output logic               pop,
  output logic [`REG_W-1:0]  rd_a,
  output logic [`REG_W-1:0]  rd_b,
  input  logic [`DATA_W-1:0] rd_a_data,
  input  logic [`DATA_W-1:0] rd_b_data,
  input  logic [`REG_N-1:0]  busy,
  output logic               set_busy,
  output logic [`REG_W-1:0]  set_dest,
  input  cdb_t               cdb,
  issue_if.source            station
);

  logic is_exec;
  logic do_issue;
  logic do_discard;
  logic a_hit;
  logic b_hit;
  logic a_rdy;
  logic b_rdy;

  // only the two arithmetic ops go to the station
  assign is_exec = (head.op == ADDF) || (head.op == MULTF);

  // dest busy means a writer is still in flight
  // so waiting here keeps one tag per register
  assign do_issue   = head_valid && is_exec && !station.full && !busy[head.dest];
  // NOP, LD, ST and unknown ops just leave the queue
  assign do_discard = head_valid && !is_exec;
  assign pop        = do_issue || do_discard;

  // register file reads already bypass the cdb
  assign rd_a = head.src_a;
  assign rd_b = head.src_b;

  // result landing this cycle counts as present
  assign a_hit = cdb.valid && (cdb.dest == head.src_a);
  assign b_hit = cdb.valid && (cdb.dest == head.src_b);
  // r0 is never busy, so it is always ready
  assign a_rdy = (head.src_a == '0) || !busy[head.src_a] || a_hit;
  assign b_rdy = (head.src_b == '0) || !busy[head.src_b] || b_hit;

  assign station.valid   = do_issue;
  assign station.op      = head.op;
  assign station.dest    = head.dest;
  assign station.a_ready = a_rdy;
  assign station.b_ready = b_rdy;
  // pending operand travels as its tag
  assign station.a_data  = a_rdy ? rd_a_data : `DATA_W'(head.src_a);
  assign station.b_data  = b_rdy ? rd_b_data : `DATA_W'(head.src_b);

  // busy bit goes up on the issue edge
  assign set_busy = do_issue;
  assign set_dest = head.dest;

endmodule

`default_nettype wire

//--- reg_status_file.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// reg_status_file, 8 x 32 regs,
// busy bits, cdb write and bypass
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

`include "tomasulo_defines.svh"

module reg_status_file import tomasulo_pkg::*; (
  input  logic               clk,
  input  logic               rst,
  input  logic [`REG_W-1:0]  rd_a,
  input  logic [`REG_W-1:0]  rd_b,
  output logic [`DATA_W-1:0] rd_a_data,
  output logic [`DATA_W-1:0] rd_b_data,
  input  logic               set_busy,
  input  logic [`REG_W-1:0]  set_dest,
  input  cdb_t               cdb,
  output logic [`REG_N-1:0]  busy
);

  // r0 has no storage and no busy bit
  logic [`DATA_W-1:0] regs_q [1:`REG_N-1];
  logic [`REG_N-1:1]  busy_q;
  logic               wr_en;

  // writes to r0 are reported on the bus but dropped here
  assign wr_en = cdb.valid && (cdb.dest != '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      // register r starts out holding r
      for (int r = 1; r < `REG_N; r++) begin
        regs_q[r] <= `DATA_W'(r);
      end
      busy_q <= '0;
    end else begin
      if (wr_en) begin
        regs_q[cdb.dest] <= cdb.data;
        busy_q[cdb.dest] <= 1'b0;
      end
      // issue never targets a busy reg, so set and clear never collide
      if (set_busy && (set_dest != '0)) begin
        busy_q[set_dest] <= 1'b1;
      end
    end
  end

  assign busy = {busy_q, 1'b0};

  // combinational read with same-cycle cdb bypass
  assign rd_a_data = (rd_a == '0)                   ? '0       :
                     (wr_en && (cdb.dest == rd_a))  ? cdb.data :
                                                      regs_q[rd_a];
  assign rd_b_data = (rd_b == '0)                   ? '0       :
                     (wr_en && (cdb.dest == rd_b))  ? cdb.data :
                                                      regs_q[rd_b];

endmodule

`default_nettype wire

//--- reservation_station.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// reservation_station, entries,
// cdb snooping, oldest-ready dispatch
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

`include "tomasulo_defines.svh"

module reservation_station import tomasulo_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  issue_if.sink   station,
  input  cdb_t    cdb,
  exec_if.source  exec
);

  localparam int N     = `STATION_DEPTH;
  localparam int IDX_W = $clog2(N);

  // control state per entry
  logic [N-1:0]       ent_valid;
  logic [N-1:0]       a_rdy;
  logic [N-1:0]       b_rdy;
  // larger age means older entry
  logic [IDX_W-1:0]   age [N];
  // payload per entry
  opcode_t            op_q   [N];
  logic [`REG_W-1:0]  dest_q [N];
  logic [`DATA_W-1:0] a_q    [N];
  logic [`DATA_W-1:0] b_q    [N];

  logic [N-1:0]       snoop_a;
  logic [N-1:0]       snoop_b;
  logic               alloc_en;
  logic [IDX_W-1:0]   free_idx;
  logic               sel_found;
  logic [IDX_W-1:0]   sel_idx;
  logic [IDX_W-1:0]   sel_age;

  assign station.full = &ent_valid;
  assign alloc_en     = station.valid && !station.full;

  // waiting operands hold their tag in the low data bits
  always_comb begin
    for (int i = 0; i < N; i++) begin
      snoop_a[i] = ent_valid[i] && !a_rdy[i] && cdb.valid &&
                   (cdb.dest == a_q[i][`REG_W-1:0]);
      snoop_b[i] = ent_valid[i] && !b_rdy[i] && cdb.valid &&
                   (cdb.dest == b_q[i][`REG_W-1:0]);
    end
  end

  // lowest free slot takes the new entry
  always_comb begin
    free_idx = '0;
    for (int i = N - 1; i >= 0; i--) begin
      if (!ent_valid[i]) free_idx = IDX_W'(i);
    end
  end

  // flags are registered, so a capture dispatches one cycle later
  always_comb begin
    sel_found = 1'b0;
    sel_idx   = '0;
    sel_age   = '0;
    for (int i = 0; i < N; i++) begin
      if (ent_valid[i] && a_rdy[i] && b_rdy[i] && (!sel_found || age[i] > sel_age)) begin
        sel_found = 1'b1;
        sel_idx   = IDX_W'(i);
        sel_age   = age[i];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ent_valid <= '0;
      a_rdy     <= '0;
      b_rdy     <= '0;
      for (int i = 0; i < N; i++) age[i] <= '0;
    end else begin
      for (int i = 0; i < N; i++) begin
        if (alloc_en && (free_idx == IDX_W'(i))) begin
          ent_valid[i] <= 1'b1;
          a_rdy[i]     <= station.a_ready;
          b_rdy[i]     <= station.b_ready;
          age[i]       <= '0;
        end else begin
          if (sel_found && (sel_idx == IDX_W'(i))) ent_valid[i] <= 1'b0;
          if (snoop_a[i]) a_rdy[i] <= 1'b1;
          if (snoop_b[i]) b_rdy[i] <= 1'b1;
          // age counts the residents that came in later
          // every newcomer makes the residents one step older
          // a younger entry leaving takes one step back
          if (ent_valid[i]) begin
            age[i] <= age[i] + IDX_W'(alloc_en)
                      - IDX_W'(sel_found && (age[i] > sel_age));
          end
        end
      end
    end
  end

  // payload, operand value replaces the tag on a snoop hit
  always_ff @(posedge clk) begin
    for (int i = 0; i < N; i++) begin
      if (alloc_en && (free_idx == IDX_W'(i))) begin
        op_q[i]   <= station.op;
        dest_q[i] <= station.dest;
        a_q[i]    <= station.a_data;
        b_q[i]    <= station.b_data;
      end else begin
        if (snoop_a[i]) a_q[i] <= cdb.data;
        if (snoop_b[i]) b_q[i] <= cdb.data;
      end
    end
  end

  assign exec.valid = sel_found;
  assign exec.op    = op_q[sel_idx];
  assign exec.dest  = dest_q[sel_idx];
  assign exec.a     = a_q[sel_idx];
  assign exec.b     = b_q[sel_idx];

endmodule

`default_nettype wire

//--- exec_pipe.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// exec_pipe, add/multiply pipeline
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

`include "tomasulo_defines.svh"

module exec_pipe import tomasulo_pkg::*; (
  input  logic   clk,
  input  logic   rst,
  exec_if.sink   exec,
  output cdb_t   cdb
);

  localparam int N = `EXEC_STAGES;

  logic [N-1:0]       vld_q;
  logic [`REG_W-1:0]  dest_q [N];
  logic [`DATA_W-1:0] data_q [N];
  logic [`DATA_W-1:0] result;

  // whole result computed up front, later stages only carry it
  // product keeps the low 32 bits
  assign result = (exec.op == MULTF) ? exec.a * exec.b : exec.a + exec.b;

  // valid shifts through, up to three ops in flight
  always_ff @(posedge clk) begin
    if (rst) begin
      vld_q <= '0;
    end else begin
      vld_q <= {vld_q[N-2:0], exec.valid};
    end
  end

  always_ff @(posedge clk) begin
    dest_q[0] <= exec.dest;
    data_q[0] <= result;
    for (int s = 1; s < N; s++) begin
      dest_q[s] <= dest_q[s-1];
      data_q[s] <= data_q[s-1];
    end
  end

  // last stage is the common data bus
  assign cdb = '{valid: vld_q[N-1], dest: dest_q[N-1], data: data_q[N-1]};

endmodule

`default_nettype wire

//--- tomasulo_core.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// tomasulo_core, RTL top level
// queue, issue, regs, station, exec
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

`include "tomasulo_defines.svh"

module tomasulo_core import tomasulo_pkg::*; (
  input  logic                busySelect,
  input  logic                rst,
  input  logic                instr_valid,
  input  logic [`INSTR_W-1:0] instr,
  output logic                queue_full,
  output logic                wb_valid,
  output logic [`REG_W-1:0]   wb_dest,
  output logic [`DATA_W-1:0]  wb_data,
  output logic [`REG_N-1:0]   busy_regs
);

  instr_t             queue_head;
  logic               queue_head_valid;
  logic               queue_pop;
  logic [`REG_W-1:0]  rd_a;
  logic [`REG_W-1:0]  rd_b;
  logic [`DATA_W-1:0] rd_a_data;
  logic [`DATA_W-1:0] rd_b_data;
  logic [`REG_N-1:0]  busy;
  logic               set_busy;
  logic [`REG_W-1:0]  set_dest;
  cdb_t               cdb;

  issue_if issue_bus ();
  exec_if  exec_bus ();

  instr_queue i_instr_queue (
    .clk        (busySelect),
    .rst        (rst),
    .push       (instr_valid),
    .push_data  (instr_t'(instr)),
    .pop        (queue_pop),
    .head       (queue_head),
    .head_valid (queue_head_valid),
    .full       (queue_full)
  );

  issue_unit i_issue_unit (
    .head       (queue_head),
    .head_valid (queue_head_valid),
    .pop        (queue_pop),
    .rd_a       (rd_a),
    .rd_b       (rd_b),
    .rd_a_data  (rd_a_data),
    .rd_b_data  (rd_b_data),
    .busy       (busy),
    .set_busy   (set_busy),
    .set_dest   (set_dest),
    .cdb        (cdb),
    .station    (issue_bus.source)
  );

  reg_status_file i_reg_status_file (
    .clk       (busySelect),
    .rst       (rst),
    .rd_a      (rd_a),
    .rd_b      (rd_b),
    .rd_a_data (rd_a_data),
    .rd_b_data (rd_b_data),
    .set_busy  (set_busy),
    .set_dest  (set_dest),
    .cdb       (cdb),
    .busy      (busy)
  );

  reservation_station i_reservation_station (
    .clk     (busySelect),
    .rst     (rst),
    .station (issue_bus.sink),
    .cdb     (cdb),
    .exec    (exec_bus.source)
  );

  exec_pipe i_exec_pipe (
    .clk  (busySelect),
    .rst  (rst),
    .exec (exec_bus.sink),
    .cdb  (cdb)
  );

  // writeback ports mirror the cdb
  assign wb_valid  = cdb.valid;
  assign wb_dest   = cdb.dest;
  assign wb_data   = cdb.data;
  assign busy_regs = busy;

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench clock and reset
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
  parameter int HALF_PERIOD  = 4,
  parameter int RESET_CYCLES = 8
) (
  output logic clk,
  output logic rst
);

  // 8 ns period
  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD) clk = ~clk;
  end

  // reset held for a fixed number of rising edges
  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

`default_nettype wire

//--- tb_checker.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// in-order register model
// writeback compare and error counts
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

`include "tomasulo_defines.svh"

module tb_checker import tomasulo_pkg::*; (
  input logic                clk,
  input logic                rst,
  input logic                instr_valid,
  input logic [`INSTR_W-1:0] instr,
  input logic                queue_full,
  input logic                wb_valid,
  input logic [`REG_W-1:0]   wb_dest,
  input logic [`DATA_W-1:0]  wb_data,
  input logic [`REG_N-1:0]   busy_regs
);

  logic [`DATA_W-1:0] model [`REG_N];
  // expected results in strobe order
  logic [`REG_W-1:0]  exp_dest [$];
  logic [`DATA_W-1:0] exp_data [$];
  int                 mismatches   = 0;
  int                 other_errors = 0;
  int                 sent_exec    = 0;
  int                 wb_count     = 0;
  logic               full_seen    = 1'b0;
  string              test_name    = "none";
  instr_t             word;
  logic [`DATA_W-1:0] result;
  int                 hit;

  // oldest pending result for a register
  // r0 is never busy so its writers can finish out of order
  function automatic int find_expected(input logic [`REG_W-1:0] d,
                                       input logic [`DATA_W-1:0] v);
    int idx;
    idx = -1;
    for (int i = 0; i < exp_dest.size(); i++) begin
      if (idx < 0 && exp_dest[i] == d && (d != '0 || exp_data[i] == v)) begin
        idx = i;
      end
    end
    for (int i = 0; i < exp_dest.size(); i++) begin
      if (idx < 0 && exp_dest[i] == d) begin
        idx = i;
      end
    end
    return idx;
  endfunction

  always @(posedge clk) begin
    if (rst) begin
      // register r starts out holding r, so r0 holds zero
      for (int r = 0; r < `REG_N; r++) begin
        model[r] = `DATA_W'(r);
      end
      exp_dest.delete();
      exp_data.delete();
    end else begin
      if (queue_full) begin
        full_seen = 1'b1;
      end
      if (wb_valid) begin
        wb_count++;
        hit = find_expected(wb_dest, wb_data);
        if (hit < 0) begin
          note_failure($sformatf("writeback to r%0d data %h matches no instruction",
                                 wb_dest, wb_data));
        end else begin
          expect_value($sformatf("writeback r%0d", wb_dest), exp_data[hit], wb_data);
          exp_dest.delete(hit);
          exp_data.delete(hit);
        end
      end
      // sequential execution of every accepted strobe
      if (instr_valid && !queue_full) begin
        word = instr_t'(instr);
        if (word.op == ADDF || word.op == MULTF) begin
          // 32-bit result keeps the sum mod 2^32 or the low product
          if (word.op == ADDF) begin
            result = model[word.src_a] + model[word.src_b];
          end else begin
            result = model[word.src_a] * model[word.src_b];
          end
          exp_dest.push_back(word.dest);
          exp_data.push_back(result);
          sent_exec++;
          if (word.dest != '0) begin
            model[word.dest] = result;
          end
        end
      end
    end
  end

  task automatic set_test(input string name);
    test_name = name;
  endtask

  task automatic note_failure(input string what);
    other_errors++;
    $display("ERROR %s: %s", test_name, what);
  endtask

  task automatic expect_value(input string what, input logic [`DATA_W-1:0] exp,
                              input logic [`DATA_W-1:0] act);
    if (act !== exp) begin
      mismatches++;
      $display("MISMATCH %s %s: expected %h actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic check_idle();
    expect_value("queue_full", '0, `DATA_W'(queue_full));
    expect_value("wb_valid", '0, `DATA_W'(wb_valid));
    expect_value("busy_regs", '0, `DATA_W'(busy_regs));
  endtask

  // start looking for queue_full afresh
  task automatic clear_full_seen();
    full_seen = 1'b0;
  endtask

  task automatic check_full_seen();
    if (!full_seen) begin
      note_failure("queue_full never rose during the burst");
    end
  endtask

  // everything sent has come back exactly once
  task automatic check_drained();
    check_idle();
    expect_value("outstanding results", '0, `DATA_W'(exp_dest.size()));
    expect_value("writeback count", `DATA_W'(sent_exec), `DATA_W'(wb_count));
  endtask

  function automatic int pending_count();
    return exp_dest.size();
  endfunction

  function automatic int total_errors();
    return mismatches + other_errors;
  endfunction

  task automatic report_summary(input int assert_fails);
    $display("checker: %0d mismatches, %0d other, %0d assert fails, %0d of %0d writebacks",
             mismatches, other_errors, assert_fails, wb_count, sent_exec);
  endtask

endmodule

`default_nettype wire

//--- tomasulo_assertions.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// port protocol assertions
// bound to tomasulo_core
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

`include "tomasulo_defines.svh"

module tomasulo_assertions (
  input logic              clk,
  input logic              rst,
  input logic              instr_valid,
  input logic              queue_full,
  input logic              wb_valid,
  input logic [`REG_W-1:0] wb_dest,
  input logic [`REG_N-1:0] busy_regs
);

  int fail_count = 0;

  // a strobe only while the queue has room
  strobe_with_room: assert property (
    @(posedge clk) disable iff (rst) instr_valid |-> !queue_full
  ) else begin
    fail_count++;
    $error("instruction strobed while queue_full was high");
  end

  // r0 has no busy bit
  r0_never_busy: assert property (
    @(posedge clk) disable iff (rst) wb_valid |-> !busy_regs[0]
  ) else begin
    fail_count++;
    $error("register 0 shown busy during a writeback");
  end

  // bus write frees its register on the next cycle
  wb_clears_busy: assert property (
    @(posedge clk) disable iff (rst)
    (wb_valid && wb_dest != '0) |=> !busy_regs[$past(wb_dest)]
  ) else begin
    fail_count++;
    $error("busy bit still set after its writeback");
  end

endmodule

`default_nettype wire

//--- tb_tomasulo.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench top with LFSR stimulus
// DUT, checker and assertion bind
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

`include "tomasulo_defines.svh"

module tb_tomasulo import tomasulo_pkg::*; ();

  localparam logic [31:0] LFSR_SEED    = 32'h773e5857;
  localparam logic [31:0] LFSR_TAPS    = 32'hb4bcd35c;
  localparam int          RANDOM_COUNT = 120;
  localparam int          BURST_COUNT  = 20;
  localparam int          WAIT_LIMIT   = 400;

  logic                busySelect;
  logic                rst;
  logic                instr_valid;
  logic [`INSTR_W-1:0] instr;
  logic                queue_full;
  logic                wb_valid;
  logic [`REG_W-1:0]   wb_dest;
  logic [`DATA_W-1:0]  wb_data;
  logic [`REG_N-1:0]   busy_regs;
  logic [31:0]         lfsr_state;

  tb_clock_gen i_clock_gen (.clk(busySelect), .rst(rst));

  tomasulo_core i_tomasulo_core (
    .busySelect  (busySelect),
    .rst         (rst),
    .instr_valid (instr_valid),
    .instr       (instr),
    .queue_full  (queue_full),
    .wb_valid    (wb_valid),
    .wb_dest     (wb_dest),
    .wb_data     (wb_data),
    .busy_regs   (busy_regs)
  );

  tb_checker i_checker (
    .clk         (busySelect),
    .rst         (rst),
    .instr_valid (instr_valid),
    .instr       (instr),
    .queue_full  (queue_full),
    .wb_valid    (wb_valid),
    .wb_dest     (wb_dest),
    .wb_data     (wb_data),
    .busy_regs   (busy_regs)
  );

  bind tomasulo_core tomasulo_assertions i_tomasulo_assertions (
    .clk         (busySelect),
    .rst         (rst),
    .instr_valid (instr_valid),
    .queue_full  (queue_full),
    .wb_valid    (wb_valid),
    .wb_dest     (wb_dest),
    .busy_regs   (busy_regs)
  );

  // galois step, shifts right and folds the taps on a one
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
  endfunction

  // one step per bit taken
  task automatic draw_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  // three draws in four stay on r0..r3 so chains form often
  task automatic draw_reg(output logic [`REG_W-1:0] r);
    logic [31:0] v;
    draw_bits(2, v);
    if (v[1:0] != 2'b00) begin
      draw_bits(2, v);
    end else begin
      draw_bits(3, v);
    end
    r = v[`REG_W-1:0];
  endtask

  // mostly arithmetic, otherwise any 3-bit code
  task automatic draw_op(output logic [`OP_W-1:0] op);
    logic [31:0] v;
    draw_bits(2, v);
    case (v[1:0])
      2'd0, 2'd1: op = ADDF;
      2'd2:       op = MULTF;
      default: begin
        draw_bits(3, v);
        op = v[`OP_W-1:0];
      end
    endcase
  endtask

  // a quiet cycle before each strobe keeps queue_full current
  task automatic send_word(input logic [`INSTR_W-1:0] word);
    int waited;
    waited = 0;
    @(posedge busySelect);
    instr_valid <= 1'b0;
    @(posedge busySelect);
    while (queue_full && waited < WAIT_LIMIT) begin
      waited++;
      @(posedge busySelect);
    end
    if (queue_full) begin
      i_checker.note_failure("queue_full stayed high and the queue never drained");
      finish_run();
    end else begin
      instr_valid <= 1'b1;
      instr       <= word;
    end
  endtask

  task automatic send_random();
    logic [`OP_W-1:0]  op;
    logic [`REG_W-1:0] dest;
    logic [`REG_W-1:0] src_a;
    logic [`REG_W-1:0] src_b;
    logic [31:0]       gap;
    draw_op(op);
    draw_reg(dest);
    draw_reg(src_a);
    draw_reg(src_b);
    send_word({op, dest, src_a, src_b});
    // now and then an extra idle cycle
    draw_bits(2, gap);
    if (gap[1:0] == 2'b00) begin
      @(posedge busySelect);
      instr_valid <= 1'b0;
    end
  endtask

  task automatic wait_reset_release();
    int waited;
    waited = 0;
    @(posedge busySelect);
    while (rst && waited < WAIT_LIMIT) begin
      waited++;
      @(posedge busySelect);
    end
    if (rst) begin
      i_checker.note_failure("reset was never released");
      finish_run();
    end
  endtask

  // sampled mid-cycle where the checker state has settled
  task automatic wait_drained();
    int   waited;
    logic active;
    waited = 0;
    @(posedge busySelect);
    instr_valid <= 1'b0;
    @(negedge busySelect);
    active = (i_checker.pending_count() != 0) || (busy_regs != '0) || queue_full;
    while (active && waited < WAIT_LIMIT) begin
      waited++;
      @(negedge busySelect);
      active = (i_checker.pending_count() != 0) || (busy_regs != '0) || queue_full;
    end
    if (active) begin
      i_checker.note_failure("results still outstanding after the drain wait");
      finish_run();
    end else begin
      // quiet window to catch stray writebacks
      repeat (4 * `EXEC_STAGES) @(negedge busySelect);
    end
  endtask

  task automatic finish_run();
    int assert_fails;
    int total;
    assert_fails = i_tomasulo_core.i_tomasulo_assertions.fail_count;
    total        = i_checker.total_errors() + assert_fails;
    i_checker.report_summary(assert_fails);
    if (total == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  endtask

  initial begin
    logic [31:0] v;
    instr_valid = 1'b0;
    instr       = '0;
    lfsr_state  = LFSR_SEED;
    wait_reset_release();
    i_checker.set_test("reset");
    i_checker.check_idle();
    // r0 result is reported but reads of r0 stay zero
    i_checker.set_test("r0_write");
    send_word({ADDF, 3'd0, 3'd1, 3'd2});
    send_word({ADDF, 3'd3, 3'd0, 3'd0});
    send_word({MULTF, 3'd4, 3'd0, 3'd5});
    // dropped at issue with no writeback
    i_checker.set_test("discard");
    send_word({NOP, 3'd1, 3'd1, 3'd1});
    send_word({LD, 3'd2, 3'd1, 3'd1});
    send_word({ST, 3'd3, 3'd1, 3'd1});
    send_word({3'd7, 3'd6, 3'd1, 3'd1});
    i_checker.set_test("random");
    for (int n = 0; n < RANDOM_COUNT; n++) begin
      send_random();
    end
    // dependent chain on r5 backs up the queue
    i_checker.set_test("burst");
    i_checker.clear_full_seen();
    for (int n = 0; n < BURST_COUNT; n++) begin
      draw_bits(4, v);
      send_word({(v[3] ? MULTF : ADDF), 3'd5, 3'd5, v[2:0]});
    end
    i_checker.check_full_seen();
    i_checker.set_test("drain");
    wait_drained();
    i_checker.check_drained();
    finish_run();
  end

endmodule

`default_nettype wire

//--- build.f
+incdir+.
tomasulo_pkg.sv
tomasulo_ifs.sv
instr_queue.sv
issue_unit.sv
reg_status_file.sv
reservation_station.sv
exec_pipe.sv
tomasulo_core.sv
tb_clock_gen.sv
tb_checker.sv
tomasulo_assertions.sv
tb_tomasulo.sv
